//--- openadc_pkg.sv
`default_nettype none

package openadc_pkg;

   // sample and register widths
   typedef logic [11:0] adc_sample_t;
   typedef logic [7:0]  reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   typedef logic [1:0]  led_sel_t;

   // register map
   // bit 1 data source (1 = adc), bits 3:2 led select
   localparam reg_addr_t ADDR_CONTROL = 8'h00;
   localparam reg_addr_t ADDR_ARM     = 8'h01; // write bit 0 to arm
   localparam reg_addr_t ADDR_STATUS  = 8'h02; // read only
   localparam reg_addr_t ADDR_GAIN    = 8'h03;
   localparam reg_addr_t ADDR_TRIG_LO = 8'h04;
   localparam reg_addr_t ADDR_TRIG_HI = 8'h05; // low nibble only

   // control register fields
   localparam int CTRL_SOURCE_BIT = 1;
   localparam int CTRL_LED_LSB    = 2;
   localparam int CTRL_LED_MSB    = 3;

   // status register fields
   localparam int STATUS_ARMED_BIT = 0;
   localparam int STATUS_FIRED_BIT = 7;

   // led source codes
   localparam led_sel_t LED_STATUS    = 2'd0;
   localparam led_sel_t LED_HEARTBEAT = 2'd1;
   localparam led_sel_t LED_FLASH_A   = 2'd2;
   localparam led_sel_t LED_FLASH_B   = 2'd3;

   // trigger level msb picks the compare direction
   localparam int TRIG_DIR_BIT = 11;

endpackage

`default_nettype wire

//--- adc_trig_if.sv
`default_nettype none

interface adc_trig_if;

   logic                    arm;         // one-cycle pulse
   logic                    data_source; // 1 = adc, 0 = counter
   openadc_pkg::adc_sample_t trig_level;
   logic                    armed;
   logic                    fired;       // since last arm

   modport ctrl (
      output arm, data_source, trig_level,
      input  armed, fired
   );

   modport path (
      input  arm, data_source, trig_level,
      output armed, fired
   );

endinterface

`default_nettype wire

//--- adc_control.sv
`default_nettype none

module adc_control (
   input  wire                     clk_usb,
   input  wire                     reset,

   input  wire openadc_pkg::reg_addr_t reg_address_i,
   input  wire openadc_pkg::reg_data_t reg_datai_i,
   input  wire                     reg_read_i,
   input  wire                     reg_write_i,
   output openadc_pkg::reg_data_t  reg_datao_o,

   adc_trig_if.ctrl                trig,

   output openadc_pkg::led_sel_t   led_select_o,
   output logic                    amp_gain_o
);

   logic                     data_source;
   openadc_pkg::led_sel_t    led_select;
   openadc_pkg::reg_data_t   gain;
   openadc_pkg::adc_sample_t trig_level;
   logic                     arm;
   logic [8:0]               pwm_acc;

   // register writes
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         data_source <= 1'b0;
         led_select  <= openadc_pkg::LED_STATUS;
         gain        <= '0;
         trig_level  <= '0;
         arm         <= 1'b0;
      end else begin
         arm <= 1'b0;
         if (reg_write_i) begin
            case (reg_address_i)
               openadc_pkg::ADDR_CONTROL: begin
                  data_source <= reg_datai_i[openadc_pkg::CTRL_SOURCE_BIT];
                  led_select  <= reg_datai_i[openadc_pkg::CTRL_LED_MSB:
                                             openadc_pkg::CTRL_LED_LSB];
               end
               openadc_pkg::ADDR_ARM:     arm <= reg_datai_i[0];
               openadc_pkg::ADDR_GAIN:    gain <= reg_datai_i;
               openadc_pkg::ADDR_TRIG_LO: trig_level[7:0] <= reg_datai_i;
               openadc_pkg::ADDR_TRIG_HI: trig_level[11:8] <= reg_datai_i[3:0];
               default: ;
            endcase
         end
      end
   end

   assign trig.arm         = arm;
   assign trig.data_source = data_source;
   assign trig.trig_level  = trig_level;
   assign led_select_o     = led_select;

   // read mux, zero when idle or unmapped
   always_comb begin
      reg_datao_o = '0;
      if (reg_read_i) begin
         case (reg_address_i)
            openadc_pkg::ADDR_CONTROL: begin
               reg_datao_o[openadc_pkg::CTRL_SOURCE_BIT] = data_source;
               reg_datao_o[openadc_pkg::CTRL_LED_MSB:
                           openadc_pkg::CTRL_LED_LSB] = led_select;
            end
            openadc_pkg::ADDR_STATUS: begin
               reg_datao_o[openadc_pkg::STATUS_ARMED_BIT] = trig.armed;
               reg_datao_o[openadc_pkg::STATUS_FIRED_BIT] = trig.fired;
            end
            openadc_pkg::ADDR_GAIN:    reg_datao_o = gain;
            openadc_pkg::ADDR_TRIG_LO: reg_datao_o = trig_level[7:0];
            openadc_pkg::ADDR_TRIG_HI: reg_datao_o = {4'b0, trig_level[11:8]};
            default:                   reg_datao_o = '0;
         endcase
      end
   end

   // pwm gain: carry out of an 8-bit accumulator
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain};
   end

   assign amp_gain_o = pwm_acc[8]; // high gain/256 of the time

   // arm comes from a single-cycle write strobe
   arm_single_pulse: assert property (
      @(posedge clk_usb) disable iff (reset) arm |=> !arm
   ) else $error("arm pulse held for more than one cycle");

   // the bus never reads and writes at once
   bus_rw_exclusive: assert property (
      @(posedge clk_usb) disable iff (reset) !(reg_read_i && reg_write_i)
   ) else $error("register read and write in the same cycle");

endmodule

`default_nettype wire

//--- heartbeat_leds.sv
`default_nettype none

module heartbeat_leds #(
   parameter int pHEARTBEAT_BITS = 26
) (
   input  wire                    clk_usb,
   input  wire                    reset,
   input  wire openadc_pkg::led_sel_t led_select_i,
   input  wire                    armed_i,
   input  wire                    fired_i,
   output logic                   freq_measure_o,
   output logic                   flash_pattern_o,
   output logic                   led_armed_o,
   output logic                   led_capture_o
);

   logic [pHEARTBEAT_BITS-1:0] hb_count;
   logic                       strobe_bit_r;

   if (pHEARTBEAT_BITS < 5) begin : g_width_check
      $error("heartbeat counter needs at least 5 bits");
   end

   // free-running timer and rising-edge strobe on bit B-4
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         hb_count       <= '0;
         strobe_bit_r   <= 1'b0;
         freq_measure_o <= 1'b0;
      end else begin
         hb_count       <= hb_count + 1'b1;
         strobe_bit_r   <= hb_count[pHEARTBEAT_BITS-4];
         freq_measure_o <= hb_count[pHEARTBEAT_BITS-4] & ~strobe_bit_r;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reset)
         flash_pattern_o <= 1'b0;
      else if (hb_count[pHEARTBEAT_BITS-1]) // only during upper half
         flash_pattern_o <= ~hb_count[pHEARTBEAT_BITS-3];
   end

   // led source
   always_comb begin
      case (led_select_i)
         openadc_pkg::LED_HEARTBEAT: begin
            led_armed_o   = hb_count[pHEARTBEAT_BITS-2];
            led_capture_o = hb_count[pHEARTBEAT_BITS-1];
         end
         openadc_pkg::LED_FLASH_A, openadc_pkg::LED_FLASH_B: begin
            led_armed_o   = flash_pattern_o;
            led_capture_o = flash_pattern_o;
         end
         default: begin // status
            led_armed_o   = armed_i;
            led_capture_o = fired_i;
         end
      endcase
   end

   freq_strobe_single: assert property (
      @(posedge clk_usb) disable iff (reset) freq_measure_o |=> !freq_measure_o
   ) else $error("freq_measure_o high on consecutive cycles");

endmodule

`default_nettype wire

//--- adc_sample_path.sv
`default_nettype none

module adc_sample_path (
   input  wire                        clk_usb,
   input  wire                        reset,
   input  wire openadc_pkg::adc_sample_t adc_data_i,
   adc_trig_if.path                   trig,
   output logic                       trigger_adc_o
);

   openadc_pkg::adc_sample_t test_count;
   openadc_pkg::adc_sample_t sample_pre;
   openadc_pkg::adc_sample_t sample_cmp;
   logic                     armed;
   logic                     fired;
   logic                     level_hit;

   // test pattern source
   always_ff @(posedge clk_usb) begin
      if (reset)
         test_count <= '0;
      else
         test_count <= test_count + 1'b1;
   end

   // two-stage resample ahead of the compare
   always_ff @(posedge clk_usb) begin
      sample_pre <= trig.data_source ? adc_data_i : test_count;
      sample_cmp <= sample_pre;
   end

   // msb of the level picks above or below
   always_comb begin
      if (trig.trig_level[openadc_pkg::TRIG_DIR_BIT])
         level_hit = sample_cmp > trig.trig_level;
      else
         level_hit = sample_cmp < trig.trig_level;
   end

   // one-shot: fire once, then drop armed on the same edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed         <= 1'b0;
         fired         <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         trigger_adc_o <= armed & level_hit;

         if (trig.arm)
            armed <= 1'b1;
         else if (level_hit)
            armed <= 1'b0;

         if (trig.arm)
            fired <= 1'b0;
         else if (armed && level_hit)
            fired <= 1'b1;
      end
   end

   assign trig.armed = armed;
   assign trig.fired = fired;

   // trigger is a single-cycle pulse
   trig_single_cycle: assert property (
      @(posedge clk_usb) disable iff (reset) trigger_adc_o |=> !trigger_adc_o
   ) else $error("trigger_adc_o held for more than one cycle");

   // no trigger without being armed the cycle before
   trig_needs_arm: assert property (
      @(posedge clk_usb) disable iff (reset) trigger_adc_o |-> $past(armed)
   ) else $error("trigger_adc_o without a preceding armed cycle");

endmodule

`default_nettype wire

//--- openadc_top.sv
`default_nettype none

module openadc_top #(
   parameter int pHEARTBEAT_BITS = 26
) (
   input  wire                        clk_usb,
   input  wire                        reset,

   // register bus
   input  wire openadc_pkg::reg_addr_t   reg_address_i,
   input  wire openadc_pkg::reg_data_t   reg_datai_i,
   input  wire                        reg_read_i,
   input  wire                        reg_write_i,
   output openadc_pkg::reg_data_t     reg_datao_o,

   input  wire openadc_pkg::adc_sample_t adc_data_i,

   output logic                       trigger_adc_o,
   output logic                       amp_gain_o,
   output logic                       freq_measure_o,
   output logic                       flash_pattern_o,
   output logic                       led_armed_o,
   output logic                       led_capture_o
);

   openadc_pkg::led_sel_t led_select;

   adc_trig_if trig_bus ();

   adc_control adc_control_inst (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .reg_address_i (reg_address_i),
      .reg_datai_i   (reg_datai_i),
      .reg_read_i    (reg_read_i),
      .reg_write_i   (reg_write_i),
      .reg_datao_o   (reg_datao_o),
      .trig          (trig_bus.ctrl),
      .led_select_o  (led_select),
      .amp_gain_o    (amp_gain_o)
   );

   adc_sample_path adc_sample_path_inst (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .adc_data_i    (adc_data_i),
      .trig          (trig_bus.path),
      .trigger_adc_o (trigger_adc_o)
   );

   heartbeat_leds #(
      .pHEARTBEAT_BITS (pHEARTBEAT_BITS)
   ) heartbeat_leds_inst (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .led_select_i    (led_select),
      .armed_i         (trig_bus.armed),
      .fired_i         (trig_bus.fired),
      .freq_measure_o  (freq_measure_o),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

endmodule

`default_nettype wire

//--- tb_openadc.sv
`default_nettype none

module tb_openadc;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   localparam int HB_BITS      = 8;
   localparam int TRIG_WINDOW  = 4096;
   localparam int RUN_CYCLES   = RESET_CYCLES + 64 + 2 * TRIG_WINDOW + 64 + 64
                                 + 3 * (256 + 8) + 3 * 64 + 2 ** HB_BITS + 64;
   localparam int WATCHDOG_CYCLES = RUN_CYCLES + 1000;

   logic                     clk_usb;
   logic                     reset;
   openadc_pkg::reg_addr_t   reg_address_i;
   openadc_pkg::reg_data_t   reg_datai_i;
   logic                     reg_read_i;
   logic                     reg_write_i;
   openadc_pkg::reg_data_t   reg_datao_o;
   openadc_pkg::adc_sample_t adc_data_i;
   logic                     trigger_adc_o;
   logic                     amp_gain_o;
   logic                     freq_measure_o;
   logic                     flash_pattern_o;
   logic                     led_armed_o;
   logic                     led_capture_o;

   int error_count;
   int test_count;
   int failed_tests;
   int errors_before;

   openadc_top #(
      .pHEARTBEAT_BITS (HB_BITS)
   ) openadc_top_inst (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address_i   (reg_address_i),
      .reg_datai_i     (reg_datai_i),
      .reg_read_i      (reg_read_i),
      .reg_write_i     (reg_write_i),
      .reg_datao_o     (reg_datao_o),
      .adc_data_i      (adc_data_i),
      .trigger_adc_o   (trigger_adc_o),
      .amp_gain_o      (amp_gain_o),
      .freq_measure_o  (freq_measure_o),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

   always #(CLK_PERIOD / 2) clk_usb = ~clk_usb;

   task automatic check_value(input string test_name, input int expected, input int actual);
      assert (actual == expected) else begin
         $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_true(input string test_name, input logic cond, input string what);
      assert (cond) else begin
         $display("%s: %s", test_name, what);
         error_count++;
      end
   endtask

   task automatic reg_write(input openadc_pkg::reg_addr_t addr,
                            input openadc_pkg::reg_data_t data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_datai_i   <= data;
      reg_write_i   <= 1'b1;
      @(posedge clk_usb); // write lands on this edge
      reg_write_i   <= 1'b0;
   endtask

   task automatic reg_read(input openadc_pkg::reg_addr_t addr,
                           output openadc_pkg::reg_data_t data);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_read_i    <= 1'b1;
      @(negedge clk_usb);
      data = reg_datao_o;
      @(posedge clk_usb);
      reg_read_i    <= 1'b0;
   endtask

   function automatic openadc_pkg::adc_sample_t sample_above(input openadc_pkg::adc_sample_t lvl);
      int span;
      span = 4095 - int'(lvl);
      return 12'(int'(lvl) + 1 + int'($urandom % span));
   endfunction

   function automatic openadc_pkg::adc_sample_t sample_below(input openadc_pkg::adc_sample_t lvl);
      return 12'($urandom % int'(lvl));
   endfunction

   // cycles until the next strobe, 65 when none shows up
   task automatic cycles_to_strobe(output int gap);
      gap = 0;
      do begin
         @(negedge clk_usb);
         gap++;
      end while (!freq_measure_o && gap <= 64);
   endtask

   task automatic test_register_readback();
      string                  name;
      openadc_pkg::reg_data_t wr_val;
      openadc_pkg::reg_data_t rd_val;
      openadc_pkg::reg_addr_t addr;
      name = "register_readback";
      wr_val = 8'($urandom);
      reg_write(openadc_pkg::ADDR_CONTROL, wr_val);
      reg_read(openadc_pkg::ADDR_CONTROL, rd_val);
      check_value(name, wr_val & 8'h0e, rd_val); // bits 3:1 only
      wr_val = 8'($urandom);
      reg_write(openadc_pkg::ADDR_GAIN, wr_val);
      reg_read(openadc_pkg::ADDR_GAIN, rd_val);
      check_value(name, wr_val, rd_val);
      wr_val = 8'($urandom);
      reg_write(openadc_pkg::ADDR_TRIG_LO, wr_val);
      reg_read(openadc_pkg::ADDR_TRIG_LO, rd_val);
      check_value(name, wr_val, rd_val);
      wr_val = 8'($urandom);
      reg_write(openadc_pkg::ADDR_TRIG_HI, wr_val);
      reg_read(openadc_pkg::ADDR_TRIG_HI, rd_val);
      check_value(name, wr_val & 8'h0f, rd_val);
      addr = 8'h06 + 8'($urandom % 250);
      reg_read(addr, rd_val);
      check_value(name, 0, rd_val);
      // bus idle, mapped address
      @(posedge clk_usb);
      reg_address_i <= openadc_pkg::ADDR_GAIN;
      @(negedge clk_usb);
      check_value(name, 0, reg_datao_o);
   endtask

   task automatic test_counter_trigger();
      string                  name;
      openadc_pkg::reg_data_t status;
      int                     cycles;
      int                     pulses;
      name = "counter_trigger";
      reg_write(openadc_pkg::ADDR_CONTROL, 8'h00);
      reg_write(openadc_pkg::ADDR_TRIG_LO, 8'h00);
      reg_write(openadc_pkg::ADDR_TRIG_HI, 8'h09); // 0x900, fire above
      reg_write(openadc_pkg::ADDR_ARM, 8'h01);
      reg_read(openadc_pkg::ADDR_STATUS, status);
      check_value(name, 1, status[0]);
      cycles = 0;
      do begin
         @(negedge clk_usb);
         cycles++;
      end while (!trigger_adc_o && cycles < TRIG_WINDOW);
      check_true(name, trigger_adc_o, "no trigger pulse within 4096 cycles");
      pulses = 0;
      repeat (TRIG_WINDOW) begin
         @(negedge clk_usb);
         if (trigger_adc_o)
            pulses++;
      end
      check_value(name, 0, pulses);
      reg_read(openadc_pkg::ADDR_STATUS, status);
      check_value(name, 8'h80, status); // fired, no longer armed
   endtask

   task automatic test_adc_trigger();
      string                    name;
      openadc_pkg::adc_sample_t level;
      openadc_pkg::reg_data_t   status;
      int                       pulses;
      int                       pulse_at;
      int                       k;
      name = "adc_trigger";
      level = 12'h100 + 12'($urandom % 32'h600); // bit 11 clear, fire below
      @(posedge clk_usb);
      adc_data_i <= sample_above(level);
      reg_write(openadc_pkg::ADDR_TRIG_LO, level[7:0]);
      reg_write(openadc_pkg::ADDR_TRIG_HI, {4'h0, level[11:8]});
      reg_write(openadc_pkg::ADDR_CONTROL, 8'h02);
      reg_write(openadc_pkg::ADDR_ARM, 8'h01);
      pulses = 0;
      repeat (8) begin
         @(posedge clk_usb);
         adc_data_i <= sample_above(level);
         @(negedge clk_usb);
         if (trigger_adc_o)
            pulses++;
      end
      check_value(name, 0, pulses);
      @(posedge clk_usb);
      adc_data_i <= sample_below(level);
      pulse_at = 0;
      for (k = 1; k <= 6; k++) begin
         @(posedge clk_usb);
         adc_data_i <= sample_above(level);
         @(negedge clk_usb);
         if (trigger_adc_o) begin
            pulses++;
            pulse_at = k;
         end
      end
      check_value(name, 1, pulses);
      check_value(name, 3, pulse_at); // cycles after the low sample was driven
      reg_read(openadc_pkg::ADDR_STATUS, status);
      check_value(name, 8'h80, status);
   endtask

   task automatic test_gain_pwm();
      string                  name;
      openadc_pkg::reg_data_t gain;
      int                     high_count;
      name = "gain_pwm";
      repeat (3) begin
         gain = 8'($urandom);
         reg_write(openadc_pkg::ADDR_GAIN, gain);
         repeat (2) @(posedge clk_usb);
         high_count = 0;
         repeat (256) begin
            @(negedge clk_usb);
            if (amp_gain_o)
               high_count++;
         end
         check_value(name, gain, high_count);
      end
   endtask

   task automatic test_heartbeat_leds();
      string                  name;
      openadc_pkg::reg_data_t status;
      int                     gap;
      int                     mismatches;
      int                     toggles;
      logic                   last_flash;
      name = "heartbeat_leds";
      cycles_to_strobe(gap);
      check_true(name, gap <= 64, "freq_measure_o never pulsed");
      repeat (2) begin
         cycles_to_strobe(gap);
         check_value(name, 2 ** (HB_BITS - 3), gap);
      end
      reg_write(openadc_pkg::ADDR_CONTROL, 8'h00);
      reg_read(openadc_pkg::ADDR_STATUS, status);
      @(negedge clk_usb);
      check_value(name, status[0], led_armed_o);
      check_value(name, status[7], led_capture_o); // still fired from the adc run
      reg_write(openadc_pkg::ADDR_TRIG_LO, 8'h00);
      reg_write(openadc_pkg::ADDR_TRIG_HI, 8'h00); // below zero, never fires
      reg_write(openadc_pkg::ADDR_ARM, 8'h01);
      reg_read(openadc_pkg::ADDR_STATUS, status);
      check_value(name, 1, status[0]);
      @(negedge clk_usb);
      check_value(name, status[0], led_armed_o);
      check_value(name, status[7], led_capture_o);
      reg_write(openadc_pkg::ADDR_CONTROL, {4'h0, openadc_pkg::LED_FLASH_A, 2'b00});
      mismatches = 0;
      toggles    = 0;
      last_flash = flash_pattern_o;
      repeat (2 ** HB_BITS + 16) begin
         @(negedge clk_usb);
         if (led_armed_o !== flash_pattern_o || led_capture_o !== flash_pattern_o)
            mismatches++;
         if (flash_pattern_o !== last_flash)
            toggles++;
         last_flash = flash_pattern_o;
      end
      check_value(name, 0, mismatches);
      check_true(name, toggles > 0, "flash_pattern_o never changed");
   endtask

   task automatic report_test(input string test_name, input int errors_at_start);
      test_count++;
      if (error_count == errors_at_start) begin
         $display("%-18s ok", test_name);
      end else begin
         failed_tests++;
         $display("%-18s failed, %0d errors", test_name, error_count - errors_at_start);
      end
   endtask

   initial begin
      void'($urandom(32'h2443733b));
      error_count   = 0;
      test_count    = 0;
      failed_tests  = 0;
      clk_usb       = 1'b0;
      reset         = 1'b1;
      reg_address_i = '0;
      reg_datai_i   = '0;
      reg_read_i    = 1'b0;
      reg_write_i   = 1'b0;
      adc_data_i    = '0;
      repeat (RESET_CYCLES) @(posedge clk_usb);
      reset <= 1'b0;
      errors_before = error_count;
      test_register_readback();
      report_test("register_readback", errors_before);
      errors_before = error_count;
      test_counter_trigger();
      report_test("counter_trigger", errors_before);
      errors_before = error_count;
      test_adc_trigger();
      report_test("adc_trigger", errors_before);
      errors_before = error_count;
      test_gain_pwm();
      report_test("gain_pwm", errors_before);
      errors_before = error_count;
      test_heartbeat_leds();
      report_test("heartbeat_leds", errors_before);
      $display("tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_usb);
      $display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
openadc_pkg.sv
adc_trig_if.sv
adc_control.sv
heartbeat_leds.sv
adc_sample_path.sv
openadc_top.sv
tb_openadc.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_openadc
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
